// ==== Bender.yml ====
package:
  name: chip8

sources:
  - logic/chip8_isa_pkg.sv
  - logic/chip8_sys_pkg.sv
  - logic/chip8_alu.sv
  - logic/chip8_decoder.sv
  - logic/chip8_timers.sv
  - logic/chip8_wb_master.sv
  - logic/chip8_control.sv
  - logic/chip8_core.sv
  - target: test
    files:
      - verif/chip8_mem_model.sv
      - verif/chip8_tb.sv

// ==== chip8.f ====
logic/chip8_isa_pkg.sv
logic/chip8_sys_pkg.sv
logic/chip8_alu.sv
logic/chip8_decoder.sv
logic/chip8_timers.sv
logic/chip8_wb_master.sv
logic/chip8_control.sv
logic/chip8_core.sv
verif/chip8_mem_model.sv
verif/chip8_tb.sv

// ==== logic/chip8_alu.sv ====
`timescale 1ns/1ns

module chip8_alu import chip8_isa_pkg::*; (
  input  alu_op_e           op_i,
  input  logic [DATA_W-1:0] a_i,
  input  logic [DATA_W-1:0] b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              flag_o
);

  logic [DATA_W:0] sum;

  assign sum = {1'b0, a_i} + {1'b0, b_i};

  always_comb begin
    result_o = b_i;
    flag_o   = 1'b0;
    case (op_i)
      alu_mov: result_o = b_i;
      alu_or:  result_o = a_i | b_i;
      alu_and: result_o = a_i & b_i;
      alu_xor: result_o = a_i ^ b_i;
      alu_add: begin
        result_o = sum[DATA_W-1:0];
        flag_o   = sum[DATA_W];      // carry
      end
      alu_sub: begin
        result_o = a_i - b_i;
        flag_o   = (a_i >= b_i);     // no borrow
      end
      alu_subn: begin
        result_o = b_i - a_i;
        flag_o   = (b_i >= a_i);
      end
      alu_shr: begin
        result_o = a_i >> 1;
        flag_o   = a_i[0];
      end
      alu_shl: begin
        result_o = a_i << 1;
        flag_o   = a_i[DATA_W-1];
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/chip8_control.sv ====
`timescale 1ns/1ns

module chip8_control import chip8_isa_pkg::*, chip8_sys_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst_n_i,
  input  logic [15:0]          keymap_i,
  output logic [OPCODE_W-1:0]  opcode_o,
  input  op_e                  op_i,
  input  alu_op_e              alu_op_i,
  input  logic [REG_IDX_W-1:0] x_i,
  input  logic [REG_IDX_W-1:0] y_i,
  input  logic [DATA_W-1:0]    nn_i,
  input  logic [ADDR_W-1:0]    nnn_i,
  output logic [DATA_W-1:0]    alu_a_o,
  output logic [DATA_W-1:0]    alu_b_o,
  output alu_op_e              alu_op_o,
  input  logic [DATA_W-1:0]    alu_result_i,
  input  logic                 alu_flag_i,
  output logic                 dt_load_o,
  output logic                 st_load_o,
  output logic [DATA_W-1:0]    timer_value_o,
  input  logic [DATA_W-1:0]    delay_i,
  output logic                 bus_req_o,
  output logic                 bus_we_o,
  output logic [ADDR_W-1:0]    bus_addr_o,
  output logic [DATA_W-1:0]    bus_wdata_o,
  input  logic [DATA_W-1:0]    bus_rdata_i,
  input  logic                 bus_done_i,
  output logic                 halted_o
);

  ctrl_state_e          state_q;
  logic [ADDR_W-1:0]    pc_q;
  logic [ADDR_W-1:0]    pc_next;
  logic [SP_W-1:0]      sp_q;
  logic [REG_IDX_W-1:0] cnt_q;    // bcd digit / block register
  logic [OPCODE_W-1:0]  opcode_q;
  logic [ADDR_W-1:0]    i_q;
  logic [DATA_W-1:0]    v_q [NUM_REGS];
  logic [ADDR_W-1:0]    stack_q [STACK_DEPTH];
  logic [DATA_W-1:0]    vx;
  logic [DATA_W-1:0]    vy;
  logic [DATA_W-1:0]    bcd_digit;
  logic                 skip;
  logic                 is_xfer;
  logic                 xfer_last;
  logic                 exec;

  assign opcode_o  = opcode_q;
  assign vx        = v_q[x_i];
  assign vy        = v_q[y_i];
  assign exec      = (state_q == st_execute);
  assign halted_o  = (state_q == st_halt);
  assign is_xfer   = (op_i == op_bcd) || (op_i == op_store_block) || (op_i == op_load_block);
  assign xfer_last = (op_i == op_bcd) ? (cnt_q == REG_IDX_W'(2)) : (cnt_q == x_i);

  // 7XNN borrows the adder but never touches VF
  assign alu_op_o = (op_i == op_add_imm) ? alu_add : alu_op_i;
  assign alu_a_o  = vx;
  assign alu_b_o  = (op_i == op_add_imm) ? nn_i : vy;

  assign dt_load_o     = exec && (op_i == op_set_dt);
  assign st_load_o     = exec && (op_i == op_set_st);
  assign timer_value_o = vx;

  // bus request, fetch uses the pc, transfers walk i + cnt
  assign bus_req_o = (state_q == st_fetch_hi) || (state_q == st_fetch_lo) ||
                     (state_q == st_mem_wait);
  assign bus_we_o  = (state_q == st_mem_wait) && (op_i != op_load_block);

  always_comb begin
    case (state_q)
      st_fetch_hi: bus_addr_o = pc_q;
      st_fetch_lo: bus_addr_o = pc_q + ADDR_W'(1);
      default:     bus_addr_o = i_q + ADDR_W'(cnt_q);
    endcase
  end

  always_comb begin
    case (cnt_q)
      REG_IDX_W'(0): bcd_digit = vx / 8'd100;
      REG_IDX_W'(1): bcd_digit = (vx / 8'd10) % 8'd10;
      default:       bcd_digit = vx % 8'd10;
    endcase
  end

  assign bus_wdata_o = (op_i == op_bcd) ? bcd_digit : v_q[cnt_q];

  always_comb begin
    case (op_i)
      op_skip_eq_imm: skip = (vx == nn_i);
      op_skip_ne_imm: skip = (vx != nn_i);
      op_skip_eq_reg: skip = (vx == vy);
      op_skip_ne_reg: skip = (vx != vy);
      op_skip_key:    skip = keymap_i[vx[REG_IDX_W-1:0]];
      op_skip_nkey:   skip = !keymap_i[vx[REG_IDX_W-1:0]];
      default:        skip = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i)
      op_jp,
      op_call:    pc_next = nnn_i;
      op_ret:     pc_next = stack_q[sp_q - 1'b1] + ADDR_W'(2);  // return past the call
      op_jp_v0:   pc_next = nnn_i + ADDR_W'(v_q[0]);
      op_illegal: pc_next = pc_q;
      default:    pc_next = skip ? pc_q + ADDR_W'(4) : pc_q + ADDR_W'(2);
    endcase
  end

  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_fetch_hi;
      pc_q    <= PC_START;
      sp_q    <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        st_fetch_hi: begin
          if (bus_done_i) state_q <= st_fetch_lo;
        end
        st_fetch_lo: begin
          if (bus_done_i) state_q <= st_execute;
        end
        st_execute: begin
          pc_q  <= pc_next;
          cnt_q <= '0;
          if (op_i == op_call) begin
            sp_q <= sp_q + 1'b1;
          end else if (op_i == op_ret) begin
            sp_q <= sp_q - 1'b1;
          end
          if (op_i == op_illegal) begin
            state_q <= st_halt;
          end else if (is_xfer) begin
            state_q <= st_mem_wait;
          end else begin
            state_q <= st_fetch_hi;
          end
        end
        st_mem_wait: begin
          if (bus_done_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (xfer_last) state_q <= st_fetch_hi;
          end
        end
        default: ;  // halted until reset
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state_q == st_fetch_hi && bus_done_i) opcode_q[OPCODE_W-1:DATA_W] <= bus_rdata_i;
    if (state_q == st_fetch_lo && bus_done_i) opcode_q[DATA_W-1:0] <= bus_rdata_i;
    if (exec) begin
      case (op_i)
        op_call:    stack_q[sp_q] <= pc_q;
        op_ld_imm:  v_q[x_i] <= nn_i;
        op_add_imm: v_q[x_i] <= alu_result_i;
        op_alu_reg: begin
          v_q[x_i] <= alu_result_i;
          if (alu_op_i != alu_mov) v_q[FLAG_REG] <= alu_flag_i;  // VF last, wins over x = F
        end
        op_ld_dt:   v_q[x_i] <= delay_i;
        op_ld_i:    i_q <= nnn_i;
        op_add_i:   i_q <= i_q + ADDR_W'(vx);
        op_font_i:  i_q <= ADDR_W'(vx) * ADDR_W'(FONT_STRIDE);
        default: ;
      endcase
    end
    if (state_q == st_mem_wait && bus_done_i && op_i == op_load_block) begin
      v_q[cnt_q] <= bus_rdata_i;
    end
  end

endmodule

// ==== logic/chip8_core.sv ====
`timescale 1ns/1ns

module chip8_core import chip8_isa_pkg::*; (
  input  logic              clk_in,
  input  logic              rst_n_i,
  input  logic [15:0]       keymap_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output logic [DATA_W-1:0] wb_dat_o,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic              wb_ack_i,
  output logic              beep_o,
  output logic              halted_o
);

  logic [OPCODE_W-1:0]  opcode;
  op_e                  op;
  alu_op_e              dec_alu_op;
  alu_op_e              alu_op;
  logic [REG_IDX_W-1:0] x;
  logic [REG_IDX_W-1:0] y;
  logic [DATA_W-1:0]    nn;
  logic [ADDR_W-1:0]    nnn;
  logic [DATA_W-1:0]    alu_a;
  logic [DATA_W-1:0]    alu_b;
  logic [DATA_W-1:0]    alu_result;
  logic                 alu_flag;
  logic                 dt_load;
  logic                 st_load;
  logic [DATA_W-1:0]    timer_value;
  logic [DATA_W-1:0]    delay;
  logic                 bus_req;
  logic                 bus_we;
  logic [ADDR_W-1:0]    bus_addr;
  logic [DATA_W-1:0]    bus_wdata;
  logic [DATA_W-1:0]    bus_rdata;
  logic                 bus_done;

  chip8_control u_control (
    .clk_in        (clk_in),
    .rst_n_i       (rst_n_i),
    .keymap_i      (keymap_i),
    .opcode_o      (opcode),
    .op_i          (op),
    .alu_op_i      (dec_alu_op),
    .x_i           (x),
    .y_i           (y),
    .nn_i          (nn),
    .nnn_i         (nnn),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_op_o      (alu_op),
    .alu_result_i  (alu_result),
    .alu_flag_i    (alu_flag),
    .dt_load_o     (dt_load),
    .st_load_o     (st_load),
    .timer_value_o (timer_value),
    .delay_i       (delay),
    .bus_req_o     (bus_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_wdata_o   (bus_wdata),
    .bus_rdata_i   (bus_rdata),
    .bus_done_i    (bus_done),
    .halted_o      (halted_o)
  );

  chip8_decoder u_decoder (
    .opcode_i (opcode),
    .op_o     (op),
    .alu_op_o (dec_alu_op),
    .x_o      (x),
    .y_o      (y),
    .nn_o     (nn),
    .nnn_o    (nnn)
  );

  chip8_alu u_alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result),
    .flag_o   (alu_flag)
  );

  chip8_timers u_timers (
    .clk_in    (clk_in),
    .rst_n_i   (rst_n_i),
    .dt_load_i (dt_load),
    .st_load_i (st_load),
    .value_i   (timer_value),
    .delay_o   (delay),
    .beep_o    (beep_o)
  );

  chip8_wb_master u_wb_master (
    .clk_in   (clk_in),
    .rst_n_i  (rst_n_i),
    .req_i    (bus_req),
    .we_i     (bus_we),
    .addr_i   (bus_addr),
    .wdata_i  (bus_wdata),
    .rdata_o  (bus_rdata),
    .done_o   (bus_done),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

endmodule

// ==== logic/chip8_decoder.sv ====
`timescale 1ns/1ns

module chip8_decoder import chip8_isa_pkg::*; (
  input  logic [OPCODE_W-1:0]  opcode_i,
  output op_e                  op_o,
  output alu_op_e              alu_op_o,
  output logic [REG_IDX_W-1:0] x_o,
  output logic [REG_IDX_W-1:0] y_o,
  output logic [DATA_W-1:0]    nn_o,
  output logic [ADDR_W-1:0]    nnn_o
);

  logic [3:0] top;
  logic [3:0] n;

  assign top   = opcode_i[15:12];
  assign n     = opcode_i[3:0];
  assign x_o   = opcode_i[11:8];
  assign y_o   = opcode_i[7:4];
  assign nn_o  = opcode_i[7:0];
  assign nnn_o = opcode_i[11:0];

  always_comb begin
    op_o     = op_illegal;
    alu_op_o = alu_mov;
    case (top)
      4'h0: op_o = (opcode_i == 16'h00EE) ? op_ret : op_nop;  // other 0NNN fall through
      4'h1: op_o = op_jp;
      4'h2: op_o = op_call;
      4'h3: op_o = op_skip_eq_imm;
      4'h4: op_o = op_skip_ne_imm;
      4'h5: if (n == 4'h0) op_o = op_skip_eq_reg;
      4'h6: op_o = op_ld_imm;
      4'h7: op_o = op_add_imm;
      4'h8: begin
        op_o = op_alu_reg;
        case (n)
          4'h0: alu_op_o = alu_mov;
          4'h1: alu_op_o = alu_or;
          4'h2: alu_op_o = alu_and;
          4'h3: alu_op_o = alu_xor;
          4'h4: alu_op_o = alu_add;
          4'h5: alu_op_o = alu_sub;
          4'h6: alu_op_o = alu_shr;
          4'h7: alu_op_o = alu_subn;
          4'hE: alu_op_o = alu_shl;
          default: op_o = op_illegal;
        endcase
      end
      4'h9: if (n == 4'h0) op_o = op_skip_ne_reg;
      4'hA: op_o = op_ld_i;
      4'hB: op_o = op_jp_v0;
      4'hE: begin
        if (nn_o == 8'h9E) begin
          op_o = op_skip_key;
        end else if (nn_o == 8'hA1) begin
          op_o = op_skip_nkey;
        end
      end
      4'hF: begin
        case (nn_o)
          8'h07: op_o = op_ld_dt;
          8'h15: op_o = op_set_dt;
          8'h18: op_o = op_set_st;
          8'h1E: op_o = op_add_i;
          8'h29: op_o = op_font_i;
          8'h33: op_o = op_bcd;
          8'h55: op_o = op_store_block;
          8'h65: op_o = op_load_block;
          default: ;
        endcase
      end
      default: ;  // C and D groups not supported
    endcase
  end

endmodule

// ==== logic/chip8_isa_pkg.sv ====
package chip8_isa_pkg;

  localparam int OPCODE_W    = 16;
  localparam int ADDR_W      = 12;
  localparam int DATA_W      = 8;
  localparam int NUM_REGS    = 16;
  localparam int REG_IDX_W   = 4;
  localparam int FLAG_REG    = 15;  // VF
  localparam int FONT_STRIDE = 5;   // bytes per glyph

  localparam logic [ADDR_W-1:0] PC_START = 12'h200;

  // decoded operation classes
  typedef enum logic [4:0] {
    op_jp, op_call, op_ret, op_jp_v0,
    op_skip_eq_imm, op_skip_ne_imm, op_skip_eq_reg, op_skip_ne_reg,
    op_ld_imm, op_add_imm, op_alu_reg,
    op_ld_i, op_add_i, op_font_i,
    op_ld_dt, op_set_dt, op_set_st,
    op_skip_key, op_skip_nkey,
    op_bcd, op_store_block, op_load_block,
    op_nop, op_illegal
  } op_e;

  // 8XYN functions
  typedef enum logic [3:0] {
    alu_mov, alu_or, alu_and, alu_xor, alu_add,
    alu_sub, alu_shr, alu_subn, alu_shl
  } alu_op_e;

endpackage

// ==== logic/chip8_sys_pkg.sv ====
package chip8_sys_pkg;

  // call stack
  localparam int STACK_DEPTH = 16;
  localparam int SP_W        = 4;

  // timer tick every TIMER_DIV core clocks
  localparam int TIMER_DIV   = 200;
  localparam int TIMER_DIV_W = 8;

  typedef enum logic [2:0] {
    st_fetch_hi,
    st_fetch_lo,
    st_execute,
    st_mem_wait,  // one stay per bcd / block transfer
    st_halt
  } ctrl_state_e;

endpackage

// ==== logic/chip8_timers.sv ====
`timescale 1ns/1ns

module chip8_timers import chip8_isa_pkg::*, chip8_sys_pkg::*; (
  input  logic              clk_in,
  input  logic              rst_n_i,
  input  logic              dt_load_i,
  input  logic              st_load_i,
  input  logic [DATA_W-1:0] value_i,
  output logic [DATA_W-1:0] delay_o,
  output logic              beep_o
);

  logic [TIMER_DIV_W-1:0] div_q;
  logic [DATA_W-1:0]      delay_q;
  logic [DATA_W-1:0]      sound_q;
  logic                   tick;

  assign tick    = (div_q == TIMER_DIV_W'(TIMER_DIV - 1));
  assign delay_o = delay_q;
  assign beep_o  = (sound_q != '0);

  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q   <= '0;
      delay_q <= '0;
      sound_q <= '0;
    end else begin
      div_q <= tick ? '0 : div_q + 1'b1;
      if (dt_load_i) begin
        delay_q <= value_i;
      end else if (tick && delay_q != '0) begin
        delay_q <= delay_q - 1'b1;
      end
      if (st_load_i) begin
        sound_q <= value_i;
      end else if (tick && beep_o) begin
        sound_q <= sound_q - 1'b1;
      end
    end
  end

endmodule

// ==== logic/chip8_wb_master.sv ====
`timescale 1ns/1ns

module chip8_wb_master import chip8_isa_pkg::*; (
  input  logic              clk_in,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              done_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output logic [DATA_W-1:0] wb_dat_o,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic              wb_ack_i
);

  typedef enum logic {wb_idle, wb_busy} wb_state_e;

  wb_state_e state_q;
  logic      start;

  // request is still up while done pulses, so skip that cycle
  assign start = (state_q == wb_idle) && req_i && !done_o;

  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= wb_idle;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
      wb_we_o  <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start) begin
        state_q  <= wb_busy;
        wb_cyc_o <= 1'b1;
        wb_stb_o <= 1'b1;
        wb_we_o  <= we_i;
      end else if (state_q == wb_busy && wb_ack_i) begin
        state_q  <= wb_idle;
        wb_cyc_o <= 1'b0;
        wb_stb_o <= 1'b0;
        wb_we_o  <= 1'b0;
        done_o   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      wb_adr_o <= addr_i;
      wb_dat_o <= wdata_i;
    end
    if (state_q == wb_busy && wb_ack_i) rdata_o <= wb_dat_i;  // read data on ack
  end

endmodule

// ==== verif/chip8_mem_model.sv ====
`timescale 1ns/1ns

module chip8_mem_model import chip8_isa_pkg::*; (
  input  logic              clk_in,
  input  logic              rst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o
);

  logic [DATA_W-1:0] mem [1 << ADDR_W];  // filled by the testbench
  logic              busy_q;
  logic [1:0]        wait_q;
  logic [1:0]        draw;

  always @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      wait_q   <= '0;
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      draw = 2'($urandom_range(3, 0));
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy_q && draw != 2'd0) begin
          busy_q <= 1'b1;  // first wait state
          wait_q <= draw - 1'b1;
        end else if (busy_q && wait_q != 2'd0) begin
          wait_q <= wait_q - 1'b1;
        end else begin
          busy_q   <= 1'b0;
          wb_ack_o <= 1'b1;
          if (wb_we_i) begin
            mem[wb_adr_i] <= wb_dat_i;
          end else begin
            wb_dat_o <= mem[wb_adr_i];  // data goes out with ack
          end
        end
      end
    end
  end

endmodule

// ==== verif/chip8_tb.sv ====
`timescale 1ns/1ns

module chip8_tb import chip8_isa_pkg::*; ();

  localparam int HALT_LIMIT = 5000;
  localparam int BEEP_LIMIT = 1000;

  logic              clk_in = 1'b0;
  logic              rst_n_i;
  logic [15:0]       keymap_i;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic              wb_ack;
  logic [ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              beep;
  logic              halted;
  logic [15:0]       prog [$];
  int                test_err = 0;
  int                passes = 0;
  int                fails = 0;

  always #50 clk_in = ~clk_in;

  chip8_core u_chip8_core (
    .clk_in   (clk_in),
    .rst_n_i  (rst_n_i),
    .keymap_i (keymap_i),
    .wb_cyc_o (wb_cyc),
    .wb_stb_o (wb_stb),
    .wb_we_o  (wb_we),
    .wb_adr_o (wb_adr),
    .wb_dat_o (wb_dat_w),
    .wb_dat_i (wb_dat_r),
    .wb_ack_i (wb_ack),
    .beep_o   (beep),
    .halted_o (halted)
  );

  chip8_mem_model u_mem (
    .clk_in   (clk_in),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // {flag, result} for an 8XYN op
  function automatic logic [8:0] ref_alu(input logic [3:0] fn, input logic [7:0] a,
                                         input logic [7:0] b);
    logic [8:0] r;
    case (fn)
      4'h1: r = {1'b0, a | b};
      4'h2: r = {1'b0, a & b};
      4'h3: r = {1'b0, a ^ b};
      4'h4: r = {1'b0, a} + {1'b0, b};  // carry lands in bit 8
      4'h5: r = {a >= b, 8'(a - b)};
      4'h6: r = {a[0], 1'b0, a[7:1]};
      4'h7: r = {b >= a, 8'(b - a)};
      4'hE: r = {a[7], a[6:0], 1'b0};
      default: r = {1'b0, b};  // mov leaves VF at its old zero
    endcase
    return r;
  endfunction

  // {hundreds, tens, ones} by repeated subtraction
  function automatic logic [23:0] ref_bcd(input logic [7:0] v);
    logic [7:0] hund;
    logic [7:0] tens;
    logic [7:0] rest;
    hund = '0;
    tens = '0;
    rest = v;
    while (rest >= 8'd100) begin
      rest = rest - 8'd100;
      hund++;
    end
    while (rest >= 8'd10) begin
      rest = rest - 8'd10;
      tens++;
    end
    return {hund, tens, rest};
  endfunction

  function automatic logic [7:0] marker(input logic taken);
    return taken ? 8'h00 : 8'h01;
  endfunction

  task automatic emit(input logic [15:0] op);
    prog.push_back(op);
  endtask

  task automatic write_word(input int addr, input logic [15:0] op);
    u_mem.mem[addr] = op[15:8];
    u_mem.mem[addr + 1] = op[7:0];
  endtask

  task automatic load_program();
    for (int a = 0; a < 4096; a++) u_mem.mem[a] = 8'(a ^ (a >> 4));
    for (int i = 0; i < prog.size(); i++) write_word(PC_START + 2 * i, prog[i]);
    write_word(PC_START + 2 * prog.size(), 16'hFFFF);  // illegal, halts the core
    prog.delete();
  endtask

  task automatic run_core();
    bit done;
    done = 1'b0;
    @(posedge clk_in);
    rst_n_i <= 1'b0;
    repeat (7) @(posedge clk_in);
    @(negedge clk_in);
    if (wb_cyc || wb_stb || wb_we || halted || beep) begin
      $display("core outputs were not idle during reset");
      test_err++;
    end
    @(posedge clk_in);
    rst_n_i <= 1'b1;
    for (int c = 0; c < HALT_LIMIT && !done; c++) begin
      @(negedge clk_in);
      done = halted;
    end
    if (!done) begin
      $display("core did not halt within %0d cycles", HALT_LIMIT);
      test_err++;
    end
  endtask

  task automatic wait_beep(input logic level);
    bit seen;
    seen = 1'b0;
    for (int c = 0; c < BEEP_LIMIT && !seen; c++) begin
      @(negedge clk_in);
      seen = (beep == level);
    end
    if (!seen) begin
      $display("beep_o did not go to %b within %0d cycles", level, BEEP_LIMIT);
      test_err++;
    end
  endtask

  task automatic check_byte(input string name, input int addr, input logic [7:0] exp);
    if (u_mem.mem[addr] !== exp) begin
      $display("mismatch %s at %h: expected %h, got %h", name, 12'(addr), exp,
               u_mem.mem[addr]);
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_err == 0) begin
      $display("%s passed", name);
      passes++;
    end else begin
      $display("%s failed with %0d errors", name, test_err);
      fails++;
    end
    test_err = 0;
  endtask

  initial begin
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    logic [7:0] s;
    logic [7:0] k;
    logic [7:0] off;
    logic [7:0] d;
    logic [3:0] fn;
    logic [8:0] exp;
    logic [23:0] bcd;
    logic [7:0] pre [4];
    rst_n_i = 1'b0;
    keymap_i = '0;
    void'($urandom(32'h8da7_4a01));

    for (int i = 0; i < 9; i++) begin
      fn = (i == 8) ? 4'hE : 4'(i);
      a = 8'($urandom);
      b = 8'($urandom);
      emit(16'h6F00);
      emit({8'h60, a});
      emit({8'h61, b});
      emit(16'h8010 | 16'(fn));
      emit(16'h82F0);  // VF to V2
      emit(16'hA300);
      emit(16'hF255);
      load_program();
      run_core();
      exp = ref_alu(fn, a, b);
      check_byte("v0 result", 'h300, exp[7:0]);
      check_byte("v1", 'h301, b);
      check_byte("vf flag", 'h302, {7'd0, exp[8]});
      finish_test($sformatf("alu 8xy%h a=%h b=%h", fn, a, b));
    end

    r = 8'($urandom);
    emit({8'h60, r});
    emit(16'hA310);
    emit(16'hF033);
    load_program();
    run_core();
    bcd = ref_bcd(r);
    check_byte("bcd hundreds", 'h310, bcd[23:16]);
    check_byte("bcd tens", 'h311, bcd[15:8]);
    check_byte("bcd ones", 'h312, bcd[7:0]);
    finish_test($sformatf("bcd %0d", r));

    r = 8'($urandom);
    s = 8'($urandom);
    k = 8'($urandom);
    emit({8'h60, r});
    emit({8'h61, r});
    emit({8'h62, s});
    for (int v = 3; v <= 12; v++) emit(16'(16'h6000 | (v << 8)));
    emit({8'h30, r});
    emit(16'h6401);
    emit({8'h30, k});
    emit(16'h6501);
    emit({8'h40, r});
    emit(16'h6601);
    emit(16'h5010);
    emit(16'h6701);
    emit(16'h9020);
    emit(16'h6801);
    emit({8'h40, k});
    emit(16'h6901);
    emit(16'h22C0);
    emit(16'h1000 | 16'(PC_START + 2 * (prog.size() + 2)));  // hop one op
    emit(16'h6BFF);
    emit(16'h6C77);
    emit(16'hA340);
    emit(16'hFC55);
    load_program();
    write_word('h2C0, 16'h6A5A);  // subroutine
    write_word('h2C2, 16'h00EE);
    run_core();
    check_byte("v4 3xnn", 'h344, marker(r == r));
    check_byte("v5 3xnn", 'h345, marker(r == k));
    check_byte("v6 4xnn", 'h346, marker(r != r));
    check_byte("v7 5xy0", 'h347, marker(r == r));
    check_byte("v8 9xy0", 'h348, marker(r != s));
    check_byte("v9 4xnn", 'h349, marker(r != k));
    check_byte("va call", 'h34A, 8'h5A);
    check_byte("vb jp", 'h34B, 8'h00);
    check_byte("vc jp", 'h34C, 8'h77);
    finish_test("control flow");

    for (int i = 0; i < 4; i++) begin
      k = 8'($urandom_range(15, 0));
      @(posedge clk_in);
      keymap_i <= 16'($urandom);
      emit({8'h60, k});
      emit(16'h6100);
      emit(16'h6200);
      emit(16'hE09E);
      emit(16'h6101);
      emit(16'hE0A1);
      emit(16'h6201);
      emit(16'hA350);
      emit(16'hF255);
      load_program();
      run_core();
      check_byte("v1 ex9e", 'h351, marker(keymap_i[k[3:0]]));
      check_byte("v2 exa1", 'h352, marker(!keymap_i[k[3:0]]));
      finish_test($sformatf("keys k=%h map=%h", k[3:0], keymap_i));
    end

    off = 8'($urandom_range(63, 16));
    d = 8'($urandom_range(15, 0));
    emit(16'hA360);
    emit(16'hF365);
    emit({8'h64, off});
    emit(16'hF41E);  // I must still be 0x360 here
    emit(16'hF355);
    emit({8'h65, d});
    emit(16'hF529);
    emit(16'hF155);
    load_program();
    for (int j = 0; j < 4; j++) begin
      pre[j] = 8'($urandom);
      u_mem.mem['h360 + j] = pre[j];
    end
    run_core();
    for (int j = 0; j < 4; j++) check_byte("fx1e store", 'h360 + off + j, pre[j]);
    check_byte("fx29 store v0", d * 5, pre[0]);
    check_byte("fx29 store v1", d * 5 + 1, pre[1]);
    finish_test($sformatf("block load off=%h font=%h", off, d[3:0]));

    emit(16'h6003);
    emit(16'hF018);
    load_program();
    run_core();
    wait_beep(1'b1);
    wait_beep(1'b0);
    finish_test("sound timer");

    $display("tests: %0d passed, %0d failed", passes, fails);
    if (fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
